/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - design

sources:
  - target: any(rtl, test)
    files:
      - design/rv_core_pkg.sv
      - design/rv_decode.sv
      - design/rv_execute.sv
      - design/rv_regfile.sv
      - design/rv_commit.sv
      - design/rv_core_top.sv
  - target: test
    files:
      - tests/rv_core_props.sv
      - tests/rv_core_tb.sv

/* design/rv_commit.sv */
`timescale 1ns/1ns

`include "rv_core_macros.svh"

module rv_commit (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   inst_valid,
  input  rv_core_pkg::exe_out_t  exe,
  output rv_core_pkg::xlen_t     pc,
  output logic                   we,
  output rv_core_pkg::reg_addr_t waddr,
  output rv_core_pkg::xlen_t     wdata,
  output logic                   retire_valid,
  output rv_core_pkg::xlen_t     retire_pc,
  output logic                   retire_rd_we,
  output rv_core_pkg::reg_addr_t retire_rd,
  output rv_core_pkg::xlen_t     retire_data,
  output logic                   halted,
  output logic                   trapped
);

  rv_core_pkg::core_state_e state;
  rv_core_pkg::core_state_e state_next;
  logic                     accept;
  logic                     retire;

  // strobe only counts while running
  assign accept = inst_valid && (state == rv_core_pkg::st_run);
  // illegal never retires
  assign retire = accept && !exe.is_illegal;

  // writeback port to the regfile
  assign we    = retire && exe.rd_we;
  assign waddr = exe.rd;
  assign wdata = exe.wb_data;

  always_comb begin
    state_next = state;
    if (accept) begin
      if (exe.is_illegal) begin
        state_next = rv_core_pkg::st_trapped;
      end else if (exe.is_ebreak) begin
        state_next = rv_core_pkg::st_halted;
      end
    end
  end

  // pc and fsm, halted and trapped are sticky until reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= rv_core_pkg::st_run;
      pc           <= `RV_RESET_PC;
      retire_valid <= 1'b0;
      retire_rd_we <= 1'b0;
    end else begin
      state        <= state_next;
      retire_valid <= retire;
      retire_rd_we <= we;
      if (retire) pc <= exe.next_pc;
    end
  end

  // retire record payload, only meaningful with retire_valid
  always_ff @(posedge clk) begin
    if (retire) begin
      retire_pc   <= pc;
      retire_rd   <= exe.rd;
      retire_data <= exe.wb_data;
    end
  end

  assign halted  = (state == rv_core_pkg::st_halted);
  assign trapped = (state == rv_core_pkg::st_trapped);

endmodule

/* design/rv_core_macros.svh */
`ifndef RV_CORE_MACROS_SVH
`define RV_CORE_MACROS_SVH

// datapath width, rv64
`define RV_XLEN 64

// first fetch address after reset
`define RV_RESET_PC 64'h8000_0000

// architectural integer registers, x0 included
`define RV_NUM_REGS 32

// major opcodes, inst[6:0]
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_LUI 7'b0110111
`define RV_OPC_AUIPC 7'b0010111
`define RV_OPC_JAL 7'b1101111
`define RV_OPC_JALR 7'b1100111
// only sd is accepted here, retired as nop
`define RV_OPC_STORE 7'b0100011
// ebreak lives under system
`define RV_OPC_SYSTEM 7'b1110011

`endif

/* design/rv_core_pkg.sv */
`include "rv_core_macros.svh"

package rv_core_pkg;

  // one architectural data word
  typedef logic [`RV_XLEN-1:0] xlen_t;

  // register index, 5 bits for 32 regs
  typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

  // raw instruction word
  typedef logic [31:0] inst_t;

  // decoded instruction class
  typedef enum logic [3:0] {
    inst_nop,
    inst_addi,
    inst_lui,
    inst_auipc,
    inst_jal,
    inst_jalr,
    inst_ebreak,
    inst_store_nop,
    inst_illegal
  } inst_kind_e;

  // commit fsm
  typedef enum logic [1:0] {
    st_run,
    st_halted,
    st_trapped
  } core_state_e;

  // decode to execute
  typedef struct packed {
    inst_kind_e kind;
    xlen_t      op1;
    xlen_t      op2;
    xlen_t      jmp_base;
    xlen_t      jmp_off;
    logic       jump;
    logic       rd_we;
    reg_addr_t  rd;
  } dec_out_t;

  // execute to commit
  typedef struct packed {
    xlen_t     wb_data;
    xlen_t     next_pc;
    logic      rd_we;
    reg_addr_t rd;
    logic      is_ebreak;
    logic      is_illegal;
  } exe_out_t;

endpackage

/* design/rv_core_top.sv */
`timescale 1ns/1ns

module rv_core_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   inst_valid,
  input  rv_core_pkg::inst_t     inst,
  output rv_core_pkg::xlen_t     pc,
  output logic                   retire_valid,
  output rv_core_pkg::xlen_t     retire_pc,
  output logic                   retire_rd_we,
  output rv_core_pkg::reg_addr_t retire_rd,
  output rv_core_pkg::xlen_t     retire_data,
  output logic                   halted,
  output logic                   trapped
);

  rv_core_pkg::reg_addr_t rs1_addr;
  rv_core_pkg::xlen_t     rs1_data;
  rv_core_pkg::dec_out_t  dec;
  rv_core_pkg::exe_out_t  exe;
  logic                   rf_we;
  rv_core_pkg::reg_addr_t rf_waddr;
  rv_core_pkg::xlen_t     rf_wdata;

  // decode reads the current pc from commit
  rv_decode u_decode (
    .pc       (pc),
    .inst     (inst),
    .rs1_data (rs1_data),
    .rs1_addr (rs1_addr),
    .dec      (dec)
  );

  rv_execute u_execute (
    .dec (dec),
    .pc  (pc),
    .exe (exe)
  );

  rv_regfile u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .raddr  (rs1_addr),
    .we     (rf_we),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata),
    .rdata  (rs1_data)
  );

  // pc, state and retire record
  rv_commit u_commit (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst_valid   (inst_valid),
    .exe          (exe),
    .pc           (pc),
    .we           (rf_we),
    .waddr        (rf_waddr),
    .wdata        (rf_wdata),
    .retire_valid (retire_valid),
    .retire_pc    (retire_pc),
    .retire_rd_we (retire_rd_we),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data),
    .halted       (halted),
    .trapped      (trapped)
  );

endmodule

/* design/rv_decode.sv */
`timescale 1ns/1ns

`include "rv_core_macros.svh"

module rv_decode (
  input  rv_core_pkg::xlen_t     pc,
  input  rv_core_pkg::inst_t     inst,
  input  rv_core_pkg::xlen_t     rs1_data,
  output rv_core_pkg::reg_addr_t rs1_addr,
  output rv_core_pkg::dec_out_t  dec
);

  logic [6:0]              opcode;
  logic [2:0]              func3;
  rv_core_pkg::reg_addr_t  rd;
  rv_core_pkg::reg_addr_t  rs1;
  rv_core_pkg::xlen_t      imm_i;
  rv_core_pkg::xlen_t      imm_u;
  rv_core_pkg::xlen_t      imm_j;
  rv_core_pkg::inst_kind_e kind;

  // instruction fields
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign func3  = inst[14:12];
  assign rs1    = inst[19:15];

  // i-type immediate sign extended from 12 bits
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  // u-type immediate in the upper 20 bits and sign extended past bit 31
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  // j-type immediate from scrambled bits with lsb always zero
  assign imm_j = {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // opcode classification
  always_comb begin
    kind = rv_core_pkg::inst_illegal;
    case (opcode)
      7'b000_0000: begin
        // only the all-zero word is the simulation filler
        if (inst == '0) kind = rv_core_pkg::inst_nop;
      end
      `RV_OPC_OP_IMM: begin
        // only addi among the op-imm group
        if (func3 == 3'b000) kind = rv_core_pkg::inst_addi;
      end
      `RV_OPC_LUI:   kind = rv_core_pkg::inst_lui;
      `RV_OPC_AUIPC: kind = rv_core_pkg::inst_auipc;
      `RV_OPC_JAL:   kind = rv_core_pkg::inst_jal;
      `RV_OPC_JALR: begin
        if (func3 == 3'b000) kind = rv_core_pkg::inst_jalr;
      end
      `RV_OPC_STORE: begin
        // sd only and no memory behind it
        if (func3 == 3'b011) kind = rv_core_pkg::inst_store_nop;
      end
      `RV_OPC_SYSTEM: begin
        if (func3 == 3'b000) kind = rv_core_pkg::inst_ebreak;
      end
      default: kind = rv_core_pkg::inst_illegal;
    endcase
  end

  // operand and jump selection
  always_comb begin
    dec          = '0;
    dec.kind     = kind;
    rs1_addr     = '0;
    case (kind)
      rv_core_pkg::inst_addi: begin
        rs1_addr  = rs1;
        dec.op1   = rs1_data;
        dec.op2   = imm_i;
        dec.rd_we = 1'b1;
        dec.rd    = rd;
      end
      rv_core_pkg::inst_lui: begin
        // op1 stays zero
        dec.op2   = imm_u;
        dec.rd_we = 1'b1;
        dec.rd    = rd;
      end
      rv_core_pkg::inst_auipc: begin
        dec.op1   = pc;
        dec.op2   = imm_u;
        dec.rd_we = 1'b1;
        dec.rd    = rd;
      end
      rv_core_pkg::inst_jal: begin
        // link value pc+4 and target pc+imm
        dec.op1      = pc;
        dec.op2      = 64'd4;
        dec.jmp_base = pc;
        dec.jmp_off  = imm_j;
        dec.jump     = 1'b1;
        dec.rd_we    = 1'b1;
        dec.rd       = rd;
      end
      rv_core_pkg::inst_jalr: begin
        // target from rs1 read before writeback
        rs1_addr     = rs1;
        dec.op1      = pc;
        dec.op2      = 64'd4;
        dec.jmp_base = rs1_data;
        dec.jmp_off  = imm_i;
        dec.jump     = 1'b1;
        dec.rd_we    = 1'b1;
        dec.rd       = rd;
      end
      // remaining kinds have no operands and no write
      default: begin
        dec.rd_we = 1'b0;
      end
    endcase
  end

endmodule

/* design/rv_execute.sv */
`timescale 1ns/1ns

module rv_execute (
  input  rv_core_pkg::dec_out_t dec,
  input  rv_core_pkg::xlen_t    pc,
  output rv_core_pkg::exe_out_t exe
);

  rv_core_pkg::xlen_t sum;
  rv_core_pkg::xlen_t target;
  rv_core_pkg::xlen_t pc_plus4;

  // result adder, covers addi, lui, auipc and link value
  assign sum = dec.op1 + dec.op2;

  // jump target adder, bit 0 forced low as jalr requires
  assign target = (dec.jmp_base + dec.jmp_off) & ~64'd1;

  // sequential fetch
  assign pc_plus4 = pc + 64'd4;

  always_comb begin
    exe.wb_data = sum;
    exe.next_pc = dec.jump ? target : pc_plus4;
    exe.rd_we   = dec.rd_we;
    exe.rd      = dec.rd;
    // flags so commit never looks at the kind
    exe.is_ebreak  = (dec.kind == rv_core_pkg::inst_ebreak);
    exe.is_illegal = (dec.kind == rv_core_pkg::inst_illegal);
  end

endmodule

/* design/rv_regfile.sv */
`timescale 1ns/1ns

`include "rv_core_macros.svh"

module rv_regfile (
  input  logic                   clk,
  input  logic                   arst_n,
  input  rv_core_pkg::reg_addr_t raddr,
  input  logic                   we,
  input  rv_core_pkg::reg_addr_t waddr,
  input  rv_core_pkg::xlen_t     wdata,
  output rv_core_pkg::xlen_t     rdata
);

  rv_core_pkg::xlen_t regs [`RV_NUM_REGS];

  // whole array zeroed on reset
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      // x0 writes dropped here
      regs[waddr] <= wdata;
    end
  end

  // async read, x0 hardwired
  assign rdata = (raddr == '0) ? '0 : regs[raddr];

endmodule

/* tests/rv_core_props.sv */
`timescale 1ns/1ns

module rv_core_props (
  input logic               clk,
  input logic               arst_n,
  input logic               retire_valid,
  input logic               halted,
  input logic               trapped,
  input rv_core_pkg::xlen_t pc
);

  // trapped instructions never retire
  no_retire_when_trapped: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(retire_valid && trapped)
  ) else $error("retire_valid is high while the core is trapped");

  // halted and trapped are exclusive fsm states
  halt_trap_exclusive: assert property (
    @(posedge clk) disable iff (!arst_n)
    !(halted && trapped)
  ) else $error("halted and trapped are both high");

  // jump targets and pc+4 keep fetch word aligned
  pc_word_aligned: assert property (
    @(posedge clk) disable iff (!arst_n)
    (!halted && !trapped) |-> (pc[1:0] == 2'b00)
  ) else $error("pc is not word aligned while running");

endmodule

/* tests/rv_core_tb.sv */
`timescale 1ns/1ns

`include "rv_core_macros.svh"

module rv_core_tb;

  typedef enum int {
    kind_nop, kind_addi, kind_lui, kind_auipc, kind_jal, kind_jalr, kind_ebreak, kind_sd,
    kind_illegal
  } kind_e;

  // random instructions, then directed x0, halt and trap strobes
  localparam int n_random    = 400;
  localparam int total_inst  = n_random + 13;
  localparam int cycle_limit = total_inst * 2 + 50;

  logic                   clk;
  logic                   arst_n;
  logic                   inst_valid;
  rv_core_pkg::inst_t     inst;
  rv_core_pkg::xlen_t     pc;
  logic                   retire_valid;
  rv_core_pkg::xlen_t     retire_pc;
  logic                   retire_rd_we;
  rv_core_pkg::reg_addr_t retire_rd;
  rv_core_pkg::xlen_t     retire_data;
  logic                   halted;
  logic                   trapped;

  integer seed = 32'hf113bb2d;
  int     cycles = 0;

  // reference model state
  rv_core_pkg::xlen_t       m_regs [`RV_NUM_REGS];
  rv_core_pkg::xlen_t       m_pc;
  rv_core_pkg::core_state_e m_state;
  // instruction on the ports, taken at the next edge
  logic                     p_valid;
  kind_e                    p_kind;
  rv_core_pkg::reg_addr_t   p_rd;
  rv_core_pkg::reg_addr_t   p_rs1;
  rv_core_pkg::xlen_t       p_imm;
  // expected retire record
  logic                     e_rv;
  logic                     e_rd_we;
  rv_core_pkg::reg_addr_t   e_rd;
  rv_core_pkg::xlen_t       e_rpc;
  rv_core_pkg::xlen_t       e_data;

  rv_core_top u_dut (.*);

  bind rv_core_top rv_core_props u_props (
    .clk          (clk),
    .arst_n       (arst_n),
    .retire_valid (retire_valid),
    .halted       (halted),
    .trapped      (trapped),
    .pc           (pc)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  end

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("error %s: got %h, expected %h", name, got, exp);
      $display("FAIL: see errors above");
      $fatal(1);
    end
  endtask

  // rv64 base encodings, sd carries a random rs2
  function automatic rv_core_pkg::inst_t encode_inst(input kind_e kind,
      input rv_core_pkg::reg_addr_t rd, input rv_core_pkg::reg_addr_t rs1,
      input rv_core_pkg::xlen_t imm, input logic [31:0] noise);
    case (kind)
      kind_nop:    return 32'h0;
      kind_addi:   return {imm[11:0], rs1, 3'b000, rd, `RV_OPC_OP_IMM};
      kind_lui:    return {imm[31:12], rd, `RV_OPC_LUI};
      kind_auipc:  return {imm[31:12], rd, `RV_OPC_AUIPC};
      kind_jal:    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
      kind_jalr:   return {imm[11:0], rs1, 3'b000, rd, `RV_OPC_JALR};
      kind_ebreak: return {12'h001, 13'h0, `RV_OPC_SYSTEM};
      kind_sd:     return {imm[11:5], noise[4:0], rs1, 3'b011, imm[4:0], `RV_OPC_STORE};
      // r-type op, not supported by this core
      default:     return {noise[24:0], 7'b0110011};
    endcase
  endfunction

  // retire whatever sat on the ports at this edge
  task automatic apply_model();
    rv_core_pkg::xlen_t rs1v;
    rv_core_pkg::xlen_t res;
    rv_core_pkg::xlen_t nxt;
    logic               wr;
    e_rv = 1'b0;
    if (!p_valid || m_state != rv_core_pkg::st_run) return;
    if (p_kind == kind_illegal) begin
      m_state = rv_core_pkg::st_trapped;
      return;
    end
    rs1v = m_regs[p_rs1];
    nxt  = m_pc + 64'd4;
    wr   = p_kind inside {kind_addi, kind_lui, kind_auipc, kind_jal, kind_jalr};
    case (p_kind)
      kind_addi:           res = rs1v + p_imm;
      kind_lui:            res = p_imm;
      kind_auipc:          res = m_pc + p_imm;
      kind_jal, kind_jalr: res = m_pc + 64'd4;
      default:             res = '0;
    endcase
    if (p_kind == kind_jal) nxt = (m_pc + p_imm) & ~64'd1;
    if (p_kind == kind_jalr) nxt = (rs1v + p_imm) & ~64'd1;
    e_rv    = 1'b1;
    e_rpc   = m_pc;
    e_rd_we = wr;
    e_rd    = p_rd;
    e_data  = res;
    if (wr && p_rd != 0) m_regs[p_rd] = res;
    m_pc = nxt;
    if (p_kind == kind_ebreak) m_state = rv_core_pkg::st_halted;
  endtask

  task automatic check_outputs();
    check_value("pc", pc, m_pc);
    check_value("retire_valid", retire_valid, e_rv);
    check_value("halted", halted, m_state == rv_core_pkg::st_halted);
    check_value("trapped", trapped, m_state == rv_core_pkg::st_trapped);
    if (e_rv) begin
      check_value("retire_pc", retire_pc, e_rpc);
      check_value("retire_rd_we", retire_rd_we, e_rd_we);
      if (e_rd_we) begin
        check_value("retire_rd", retire_rd, e_rd);
        check_value("retire_data", retire_data, e_data);
      end
    end
  endtask

  // one clock: model the edge, drive new inputs, check at the falling edge
  task automatic step(input logic v, input kind_e kind, input rv_core_pkg::reg_addr_t rd,
                      input rv_core_pkg::reg_addr_t rs1, input rv_core_pkg::xlen_t imm);
    logic [31:0] noise;
    logic [1:0]  want_low;
    @(posedge clk);
    apply_model();
    noise = $random(seed);
    // imm bit 0 picks the jalr target parity, target stays word aligned
    if (kind == kind_jalr) begin
      want_low = {1'b0, imm[0]};
      imm[1:0] = want_low - m_regs[rs1][1:0];
    end
    inst_valid <= v;
    inst       <= encode_inst(kind, rd, rs1, imm, noise);
    p_valid = v;
    p_kind  = kind;
    p_rd    = rd;
    p_rs1   = rs1;
    p_imm   = imm;
    @(negedge clk);
    check_outputs();
  endtask

  task automatic random_step(output bit issued);
    logic [31:0]        r;
    kind_e              kind;
    rv_core_pkg::xlen_t imm;
    r = $random(seed);
    // one cycle in four is idle
    issued = (r[1:0] != 2'b00);
    case (r[4:2])
      3'd0:       kind = kind_nop;
      3'd1, 3'd2: kind = kind_addi;
      3'd3:       kind = kind_lui;
      3'd4:       kind = kind_auipc;
      3'd5:       kind = kind_jal;
      3'd6:       kind = kind_jalr;
      default:    kind = kind_sd;
    endcase
    r = $random(seed);
    if (kind == kind_lui || kind == kind_auipc) imm = {{32{r[31]}}, r[31:12], 12'h000};
    else if (kind == kind_jal) imm = {{43{r[20]}}, r[20:2], 2'b00};
    else imm = {{52{r[11]}}, r[11:0]};
    r = $random(seed);
    step(issued, kind, r[4:0], r[9:5], imm);
  endtask

  task automatic run_random(input int n);
    int done;
    bit issued;
    done = 0;
    while (done < n) begin
      random_step(issued);
      if (issued) done++;
    end
  endtask

  // 8 cycles of reset, model cleared alongside
  task automatic apply_reset();
    @(posedge clk);
    arst_n     <= 1'b0;
    inst_valid <= 1'b0;
    p_valid = 1'b0;
    e_rv    = 1'b0;
    m_pc    = `RV_RESET_PC;
    m_state = rv_core_pkg::st_run;
    foreach (m_regs[i]) m_regs[i] = '0;
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(negedge clk);
    check_outputs();
  endtask

  initial begin
    arst_n     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    apply_reset();
    run_random(n_random / 2);
    // x0 write shows on retire, x0 still reads as zero
    step(1'b1, kind_addi, 5'd0, 5'd3, 64'd77);
    step(1'b1, kind_addi, 5'd9, 5'd0, 64'h5a);
    // odd jalr target, bit 0 cleared
    step(1'b1, kind_jalr, 5'd1, 5'd9, 64'd33);
    // ebreak retires, later strobes ignored
    step(1'b1, kind_ebreak, 5'd0, 5'd0, 64'd0);
    repeat (4) step(1'b1, kind_addi, 5'd4, 5'd4, 64'd1);
    apply_reset();
    run_random(n_random / 2);
    // illegal word traps, pc frozen afterwards
    step(1'b1, kind_illegal, 5'd0, 5'd0, 64'd0);
    repeat (4) step(1'b1, kind_addi, 5'd4, 5'd4, 64'd1);
    step(1'b0, kind_nop, 5'd0, 5'd0, 64'd0);
    $display("PASS: all tests");
    $finish;
  end

endmodule

/* verilog.f */
+incdir+design
design/rv_core_pkg.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_regfile.sv
design/rv_commit.sv
design/rv_core_top.sv
tests/rv_core_props.sv
tests/rv_core_tb.sv
